// ==== source/nand_cpu_settings.svh ====
`ifndef NAND_CPU_SETTINGS_SVH
`define NAND_CPU_SETTINGS_SVH

// program counter width.
`define PC_SIZE 8

// register and ALU data width.
`define DATA_SIZE 8

// number of architectural registers.
`define REG_COUNT 4

`endif

// ==== source/nand_cpu_pkg.sv ====
`default_nettype none

`include "nand_cpu_settings.svh"

package nand_cpu_pkg;

typedef logic [`PC_SIZE - 1 : 0] pc_t;
typedef logic [`DATA_SIZE - 1 : 0] data_t;
typedef logic [$clog2(`REG_COUNT) - 1 : 0] reg_addr_t;
typedef logic [7 : 0] instr_t;

// instruction bits 7:6.
typedef enum logic [1 : 0] {
    OP_NAND = 2'd0,
    OP_LI   = 2'd1,
    OP_ADD  = 2'd2,
    OP_BNZ  = 2'd3
} opcode_e;

typedef struct packed {
    logic retain;
    logic clear;
} pipeline_ctrl_t;

typedef struct packed {
    pc_t pc;
    instr_t instr;
} fetch_pass_t;

typedef struct packed {
    pc_t pc;
    opcode_e op;
    reg_addr_t rd;
    reg_addr_t rs;
    data_t op0;
    data_t op1;
    // low field, sign extended to pc width.
    pc_t imm;
    logic reg_write;
} decode_pass_t;

typedef struct packed {
    logic reg_write;
    reg_addr_t reg_addr;
    data_t reg_data;
    logic halt;
    pc_t pc;
} writeback_t;

typedef struct packed {
    logic taken;
    logic halt;
    pc_t target;
} branch_feedback_t;

endpackage

`default_nettype wire

// ==== source/pipeline_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipeline_reg #(
    parameter type payload_t = logic
) (
    input wire logic clk,
    input wire logic n_rst,
    input wire nand_cpu_pkg::pipeline_ctrl_t i_ctrl,
    input wire logic i_valid,
    input wire payload_t i_payload,
    output logic o_valid,
    output payload_t o_payload
);

always_ff @(posedge clk) begin
    if (~n_rst) begin
        o_valid <= 1'b0;
    end else if (~i_ctrl.retain) begin
        o_valid <= i_valid & ~i_ctrl.clear;
    end
end

// payload follows valid but is never reset.
always_ff @(posedge clk) begin
    if (~i_ctrl.retain) begin
        o_payload <= i_payload;
    end
end

endmodule

`default_nettype wire

// ==== source/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input wire logic clk,
    input wire logic n_rst,
    input wire logic i_enable,
    input wire nand_cpu_pkg::branch_feedback_t i_branch,
    input wire nand_cpu_pkg::instr_t i_instr,
    output nand_cpu_pkg::pc_t o_pc,
    output nand_cpu_pkg::fetch_pass_t o_fetch
);

import nand_cpu_pkg::*;

pc_t pc;

// a taken branch wins over a stalled fetch.
always_ff @(posedge clk) begin
    if (~n_rst) begin
        pc <= '0;
    end else if (i_branch.taken) begin
        pc <= i_branch.target;
    end else if (i_enable) begin
        pc <= pc + 1'b1;
    end
end

assign o_pc = pc;

always_comb begin
    o_fetch.pc = pc;
    o_fetch.instr = i_instr;
end

endmodule

`default_nettype wire

// ==== source/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "nand_cpu_settings.svh"

module reg_file (
    input wire logic clk,
    input wire logic n_rst,
    input wire nand_cpu_pkg::reg_addr_t i_rd_addr,
    input wire nand_cpu_pkg::reg_addr_t i_rs_addr,
    output nand_cpu_pkg::data_t o_rd_data,
    output nand_cpu_pkg::data_t o_rs_data,
    input wire nand_cpu_pkg::writeback_t i_wb,
    input wire logic i_wb_valid
);

import nand_cpu_pkg::*;

data_t regs [`REG_COUNT];
logic wr_en;

assign wr_en = i_wb_valid & i_wb.reg_write;

always_ff @(posedge clk) begin
    if (~n_rst) begin
        for (int i = 0; i < `REG_COUNT; i++) begin
            regs[i] <= '0;
        end
    end else if (wr_en) begin
        regs[i_wb.reg_addr] <= i_wb.reg_data;
    end
end

// write-through so decode sees the value retiring this cycle.
assign o_rd_data = (wr_en && i_wb.reg_addr == i_rd_addr) ? i_wb.reg_data : regs[i_rd_addr];
assign o_rs_data = (wr_en && i_wb.reg_addr == i_rs_addr) ? i_wb.reg_data : regs[i_rs_addr];

endmodule

`default_nettype wire

// ==== source/decode_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "nand_cpu_settings.svh"

module decode_unit (
    input wire nand_cpu_pkg::fetch_pass_t i_fetch,
    output nand_cpu_pkg::reg_addr_t o_rd_addr,
    output nand_cpu_pkg::reg_addr_t o_rs_addr,
    input wire nand_cpu_pkg::data_t i_rd_data,
    input wire nand_cpu_pkg::data_t i_rs_data,
    output nand_cpu_pkg::decode_pass_t o_decode
);

import nand_cpu_pkg::*;

opcode_e op;

assign op = opcode_e'(i_fetch.instr[7 : 6]);

// rs shares the low field with the immediate.
assign o_rd_addr = i_fetch.instr[5 : 4];
assign o_rs_addr = i_fetch.instr[3 : 2];

always_comb begin
    o_decode.pc = i_fetch.pc;
    o_decode.op = op;
    o_decode.rd = o_rd_addr;
    o_decode.rs = o_rs_addr;
    o_decode.op0 = i_rd_data;
    o_decode.op1 = i_rs_data;
    o_decode.imm = {{(`PC_SIZE - 4){i_fetch.instr[3]}}, i_fetch.instr[3 : 0]};
    // only bnz leaves the register file alone.
    o_decode.reg_write = (op != OP_BNZ);
end

endmodule

`default_nettype wire

// ==== source/execute_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input wire nand_cpu_pkg::decode_pass_t i_decode,
    input wire logic i_valid,
    input wire nand_cpu_pkg::writeback_t i_fwd,
    input wire logic i_fwd_valid,
    output nand_cpu_pkg::writeback_t o_wb,
    output nand_cpu_pkg::branch_feedback_t o_branch
);

import nand_cpu_pkg::*;

data_t rd_val;
data_t rs_val;
data_t result;
logic fwd_en;
logic is_bnz;
logic zero_off;

assign fwd_en = i_fwd_valid & i_fwd.reg_write;

// older result in W overrides the value read in decode.
always_comb begin
    rd_val = (fwd_en && i_fwd.reg_addr == i_decode.rd) ? i_fwd.reg_data : i_decode.op0;
    rs_val = (fwd_en && i_fwd.reg_addr == i_decode.rs) ? i_fwd.reg_data : i_decode.op1;
end

always_comb begin
    case (i_decode.op)
        OP_NAND: result = ~(rd_val & rs_val);
        OP_LI:   result = data_t'(i_decode.imm[3 : 0]);
        OP_ADD:  result = rd_val + rs_val;
        default: result = '0;
    endcase
end

assign is_bnz = i_valid & (i_decode.op == OP_BNZ);
assign zero_off = (i_decode.imm == '0);

always_comb begin
    o_branch.halt = is_bnz & zero_off;
    o_branch.taken = is_bnz & ~zero_off & (rd_val != '0);
    o_branch.target = i_decode.pc + i_decode.imm;
end

always_comb begin
    o_wb.reg_write = i_decode.reg_write;
    o_wb.reg_addr = i_decode.rd;
    o_wb.reg_data = result;
    o_wb.halt = o_branch.halt;
    o_wb.pc = i_decode.pc;
end

endmodule

`default_nettype wire

// ==== source/pipeline_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipeline_ctrl (
    input wire logic clk,
    input wire logic n_rst,
    input wire logic i_hold,
    input wire logic i_instr_valid,
    input wire nand_cpu_pkg::branch_feedback_t i_branch,
    input wire logic i_wb_halt,
    output nand_cpu_pkg::pipeline_ctrl_t o_i2d_ctrl,
    output nand_cpu_pkg::pipeline_ctrl_t o_d2a_ctrl,
    output nand_cpu_pkg::pipeline_ctrl_t o_a2w_ctrl,
    output logic o_fetch_enable,
    output logic o_halted
);

logic halting;
logic halted;
logic flush;

always_ff @(posedge clk) begin
    if (~n_rst) begin
        halting <= 1'b0;
        halted <= 1'b0;
    end else begin
        if (i_branch.halt) begin
            halting <= 1'b1;
        end
        if (i_wb_halt) begin
            halted <= 1'b1;
        end
    end
end

// the two younger instructions are dropped.
assign flush = i_branch.taken | i_branch.halt;

always_comb begin
    o_i2d_ctrl.retain = i_hold;
    o_i2d_ctrl.clear = flush | halting | ~i_instr_valid;
    o_d2a_ctrl.retain = i_hold;
    o_d2a_ctrl.clear = flush;
    // halt entry parks in W so its pc stays visible.
    o_a2w_ctrl.retain = i_hold | i_wb_halt;
    o_a2w_ctrl.clear = 1'b0;
end

assign o_fetch_enable = ~i_hold & i_instr_valid & ~i_branch.halt & ~halting;
assign o_halted = halted | i_wb_halt;

endmodule

`default_nettype wire

// ==== source/nand_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module nand_cpu (
    input wire logic clk,
    input wire logic n_rst,
    input wire logic i_hold,
    output nand_cpu_pkg::pc_t o_pc,
    input wire nand_cpu_pkg::instr_t i_instr,
    input wire logic i_instr_valid,
    output logic o_wb_valid,
    output nand_cpu_pkg::reg_addr_t o_wb_reg,
    output nand_cpu_pkg::data_t o_wb_data,
    output logic o_halted,
    output nand_cpu_pkg::pc_t o_halt_pc
);

import nand_cpu_pkg::*;

fetch_pass_t fetch_in;
fetch_pass_t fetch_out;
decode_pass_t decode_in;
decode_pass_t decode_out;
writeback_t wb_in;
writeback_t wb_out;
branch_feedback_t branch;
pipeline_ctrl_t i2d_ctrl;
pipeline_ctrl_t d2a_ctrl;
pipeline_ctrl_t a2w_ctrl;
reg_addr_t rd_addr;
reg_addr_t rs_addr;
data_t rd_data;
data_t rs_data;
logic i2d_valid;
logic d2a_valid;
logic a2w_valid;
logic fetch_enable;
logic wb_halt;

fetch_unit i_fetch_unit (
    .clk(clk),
    .n_rst(n_rst),
    .i_enable(fetch_enable),
    .i_branch(branch),
    .i_instr(i_instr),
    .o_pc(o_pc),
    .o_fetch(fetch_in)
);

pipeline_reg #(.payload_t(fetch_pass_t)) i_i2d (
    .clk(clk),
    .n_rst(n_rst),
    .i_ctrl(i2d_ctrl),
    .i_valid(i_instr_valid),
    .i_payload(fetch_in),
    .o_valid(i2d_valid),
    .o_payload(fetch_out)
);

decode_unit i_decode_unit (
    .i_fetch(fetch_out),
    .o_rd_addr(rd_addr),
    .o_rs_addr(rs_addr),
    .i_rd_data(rd_data),
    .i_rs_data(rs_data),
    .o_decode(decode_in)
);

reg_file i_reg_file (
    .clk(clk),
    .n_rst(n_rst),
    .i_rd_addr(rd_addr),
    .i_rs_addr(rs_addr),
    .o_rd_data(rd_data),
    .o_rs_data(rs_data),
    .i_wb(wb_out),
    .i_wb_valid(a2w_valid)
);

pipeline_reg #(.payload_t(decode_pass_t)) i_d2a (
    .clk(clk),
    .n_rst(n_rst),
    .i_ctrl(d2a_ctrl),
    .i_valid(i2d_valid),
    .i_payload(decode_in),
    .o_valid(d2a_valid),
    .o_payload(decode_out)
);

execute_unit i_execute_unit (
    .i_decode(decode_out),
    .i_valid(d2a_valid),
    .i_fwd(wb_out),
    .i_fwd_valid(a2w_valid),
    .o_wb(wb_in),
    .o_branch(branch)
);

pipeline_reg #(.payload_t(writeback_t)) i_a2w (
    .clk(clk),
    .n_rst(n_rst),
    .i_ctrl(a2w_ctrl),
    .i_valid(d2a_valid),
    .i_payload(wb_in),
    .o_valid(a2w_valid),
    .o_payload(wb_out)
);

assign wb_halt = a2w_valid & wb_out.halt;

pipeline_ctrl i_pipeline_ctrl (
    .clk(clk),
    .n_rst(n_rst),
    .i_hold(i_hold),
    .i_instr_valid(i_instr_valid),
    .i_branch(branch),
    .i_wb_halt(wb_halt),
    .o_i2d_ctrl(i2d_ctrl),
    .o_d2a_ctrl(d2a_ctrl),
    .o_a2w_ctrl(a2w_ctrl),
    .o_fetch_enable(fetch_enable),
    .o_halted(o_halted)
);

// a held W entry is reported once, on the cycle it leaves.
assign o_wb_valid = a2w_valid & wb_out.reg_write & ~i_hold;
assign o_wb_reg = wb_out.reg_addr;
assign o_wb_data = wb_out.reg_data;
assign o_halt_pc = wb_out.pc;

endmodule

`default_nettype wire

// ==== tb/tb_nand_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "nand_cpu_settings.svh"

module tb_nand_cpu;

import nand_cpu_pkg::*;

localparam int MEM_DEPTH = 1 << `PC_SIZE;
localparam int MAX_STEPS = 200;
localparam int TEST_COUNT = 4;

logic clk;
logic n_rst;
logic i_hold;
logic i_instr_valid;
instr_t i_instr;
pc_t o_pc;
logic o_wb_valid;
reg_addr_t o_wb_reg;
data_t o_wb_data;
logic o_halted;
pc_t o_halt_pc;

instr_t prog [MEM_DEPTH];
reg_addr_t exp_reg [MAX_STEPS];
data_t exp_data [MAX_STEPS];
int exp_count = 0;
pc_t exp_halt_pc;
bit ref_halted = 1'b0;
string test_name = "";
integer seed = 32'h2c89_8c80;
bit stalls_on = 1'b0;
bit checking = 1'b0;
bit was_checking = 1'b0;
bit halt_seen = 1'b0;
bit timed_out = 1'b0;
int got_count = 0;
int check_count = 0;
int error_count = 0;
int run_errors = 0;

nand_cpu i_nand_cpu (
    .clk(clk),
    .n_rst(n_rst),
    .i_hold(i_hold),
    .o_pc(o_pc),
    .i_instr(i_instr),
    .i_instr_valid(i_instr_valid),
    .o_wb_valid(o_wb_valid),
    .o_wb_reg(o_wb_reg),
    .o_wb_data(o_wb_data),
    .o_halted(o_halted),
    .o_halt_pc(o_halt_pc)
);

// junk on invalid cycles is nand r3, r3 and must never retire.
assign i_instr = i_instr_valid ? prog[o_pc] : 8'h3c;

initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
end

initial begin
    i_hold = 1'b0;
    i_instr_valid = 1'b0;
    forever begin
        @(posedge clk);
        if (stalls_on) begin
            i_hold <= (($random(seed) & 3) == 0);
            i_instr_valid <= (($random(seed) & 3) != 0);
        end else begin
            i_hold <= 1'b0;
            i_instr_valid <= 1'b1;
        end
    end
end

function automatic instr_t encode(opcode_e op, reg_addr_t rd, logic [3 : 0] low);
    return {op, rd, low};
endfunction

function automatic instr_t encode_rr(opcode_e op, reg_addr_t rd, reg_addr_t rs);
    return encode(op, rd, {rs, 2'b00});
endfunction

function automatic void expect_write(reg_addr_t rd, data_t value);
    exp_reg[exp_count] = rd;
    exp_data[exp_count] = value;
    exp_count++;
endfunction

// walks the program by the ISA rules and returns the number of executed instructions.
function automatic int interpret_program();
    data_t regs [`REG_COUNT];
    pc_t pc;
    pc_t offset;
    instr_t instr;
    reg_addr_t rd;
    reg_addr_t rs;
    int r;
    int steps;
    for (r = 0; r < `REG_COUNT; r++) begin
        regs[r] = '0;
    end
    pc = '0;
    steps = 0;
    exp_count = 0;
    ref_halted = 1'b0;
    while (!ref_halted && steps < MAX_STEPS) begin
        instr = prog[pc];
        rd = instr[5 : 4];
        rs = instr[3 : 2];
        offset = pc_t'(instr[3 : 0]);
        // bit 3 is the sign of the four-bit offset.
        if (instr[3]) begin
            offset = offset - pc_t'(16);
        end
        steps++;
        case (opcode_e'(instr[7 : 6]))
            OP_NAND: begin
                regs[rd] = ~(regs[rd] & regs[rs]);
                expect_write(rd, regs[rd]);
                pc = pc + 1'b1;
            end
            OP_LI: begin
                regs[rd] = data_t'(instr[3 : 0]);
                expect_write(rd, regs[rd]);
                pc = pc + 1'b1;
            end
            OP_ADD: begin
                regs[rd] = regs[rd] + regs[rs];
                expect_write(rd, regs[rd]);
                pc = pc + 1'b1;
            end
            default: begin
                if (offset == '0) begin
                    exp_halt_pc = pc;
                    ref_halted = 1'b1;
                end else if (regs[rd] != '0) begin
                    pc = pc + offset;
                end else begin
                    pc = pc + 1'b1;
                end
            end
        endcase
    end
    return steps;
endfunction

task automatic load_program(input int id);
    int a;
    for (a = 0; a < MEM_DEPTH; a++) begin
        prog[a] = instr_t'(a ^ 'h96);
    end
    if (id == 0) begin
        // alu chain, forwarding at distance 1 and 2, both branch outcomes.
        prog[0] = encode(OP_LI, 2'd0, 4'd5);
        prog[1] = encode(OP_LI, 2'd1, 4'd3);
        prog[2] = encode_rr(OP_ADD, 2'd0, 2'd1);
        prog[3] = encode_rr(OP_NAND, 2'd1, 2'd0);
        prog[4] = encode_rr(OP_ADD, 2'd1, 2'd1);
        prog[5] = encode(OP_LI, 2'd2, 4'd0);
        prog[6] = encode(OP_BNZ, 2'd2, 4'd3);
        prog[7] = encode(OP_LI, 2'd3, 4'd7);
        prog[8] = encode(OP_BNZ, 2'd3, 4'd3);
        prog[9] = encode(OP_LI, 2'd0, 4'd15);
        prog[10] = encode(OP_LI, 2'd1, 4'd15);
        prog[11] = encode_rr(OP_ADD, 2'd3, 2'd0);
        prog[12] = encode_rr(OP_NAND, 2'd2, 2'd3);
        prog[13] = encode(OP_BNZ, 2'd2, 4'd0);
        prog[14] = encode(OP_LI, 2'd0, 4'd1);
        prog[15] = encode(OP_LI, 2'd1, 4'd1);
    end else begin
        // r0 counts down by adding 0xff, r2 doubles each pass.
        prog[0] = encode(OP_LI, 2'd0, 4'd5);
        prog[1] = encode(OP_LI, 2'd1, 4'd0);
        prog[2] = encode_rr(OP_NAND, 2'd1, 2'd1);
        prog[3] = encode(OP_LI, 2'd2, 4'd3);
        prog[4] = encode_rr(OP_ADD, 2'd2, 2'd2);
        prog[5] = encode_rr(OP_ADD, 2'd0, 2'd1);
        prog[6] = encode(OP_BNZ, 2'd0, 4'b1110);
        prog[7] = encode(OP_BNZ, 2'd0, 4'd0);
        prog[8] = encode(OP_LI, 2'd3, 4'd9);
    end
endtask

task automatic compare_values(input string name, input logic [31 : 0] expected,
                              input logic [31 : 0] actual);
    check_count++;
    if (expected !== actual) begin
        $display("mismatch: %s expected %0h actual %0h", name, expected, actual);
        error_count++;
    end
endtask

always @(negedge clk) begin
    if (checking) begin
        if (!was_checking) begin
            got_count = 0;
            halt_seen = 1'b0;
            compare_values($sformatf("%s reset pc", test_name), 32'd0, 32'(o_pc));
            compare_values($sformatf("%s reset wb_valid", test_name), 32'd0, 32'(o_wb_valid));
            compare_values($sformatf("%s reset halted", test_name), 32'd0, 32'(o_halted));
        end
        if (o_wb_valid) begin
            if (got_count < exp_count) begin
                compare_values($sformatf("%s write %0d reg", test_name, got_count),
                               32'(exp_reg[got_count]), 32'(o_wb_reg));
                compare_values($sformatf("%s write %0d data", test_name, got_count),
                               32'(exp_data[got_count]), 32'(o_wb_data));
            end else begin
                $display("%s retired an extra write r%0d = %0h beyond the expected sequence",
                         test_name, o_wb_reg, o_wb_data);
                error_count++;
            end
            got_count++;
        end
        if (halt_seen && !o_halted) begin
            $display("%s dropped o_halted before reset", test_name);
            error_count++;
        end
        if (o_halted && !halt_seen) begin
            halt_seen = 1'b1;
            compare_values($sformatf("%s halt pc", test_name), 32'(exp_halt_pc), 32'(o_halt_pc));
            compare_values($sformatf("%s write count", test_name), 32'(exp_count),
                           32'(got_count));
        end
    end
    was_checking = checking;
end

task automatic run_test(input int t);
    int cycles;
    int steps;
    int limit;
    bit stalls;
    stalls = (t >= 2);
    test_name = $sformatf("%s_%s", (t % 2 == 1) ? "countdown" : "alu_branch",
                          stalls ? "stalled" : "clean");
    load_program(t % 2);
    steps = interpret_program();
    if (!ref_halted) begin
        $display("reference model found no halt in %s", test_name);
        run_errors++;
    end
    limit = 4 * steps + (stalls ? 8 * steps + 40 : 20);
    @(negedge clk);
    stalls_on = stalls;
    @(posedge clk);
    n_rst <= 1'b0;
    repeat (3) @(posedge clk);
    n_rst <= 1'b1;
    checking = 1'b1;
    cycles = 0;
    do begin
        @(posedge clk);
        cycles++;
    end while (!halt_seen && cycles < limit);
    if (!halt_seen) begin
        $display("timeout: %s did not halt within %0d cycles", test_name, limit);
        run_errors++;
        timed_out = 1'b1;
    end else begin
        // keep watching for writes that slip past the halt.
        repeat (8) @(posedge clk);
    end
    checking = 1'b0;
endtask

initial begin
    int t;
    n_rst = 1'b0;
    for (t = 0; t < TEST_COUNT && !timed_out; t++) begin
        run_test(t);
    end
    $display("checks: %0d  errors: %0d  run errors: %0d", check_count, error_count, run_errors);
    if (error_count == 0 && run_errors == 0) begin
        $display("STATUS: PASS");
    end else begin
        $display("STATUS: FAIL");
    end
    $finish;
end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+source
source/nand_cpu_pkg.sv
source/pipeline_reg.sv
source/fetch_unit.sv
source/reg_file.sv
source/decode_unit.sv
source/execute_unit.sv
source/pipeline_ctrl.sv
source/nand_cpu.sv
tb/tb_nand_cpu.sv
